// File: dac_sys.f
verilog/dac_sys_pkg.sv
verilog/axi_reg_slave.sv
verilog/pwl_dma_receiver.sv
verilog/batch_buffer.sv
verilog/dac_batch_streamer.sv
verilog/top_level.sv
sim/top_level_properties.sv
sim/top_level_tb.sv

// File: Bender.yml
package:
  name: dac_sys

sources:
  - files:
      - verilog/dac_sys_pkg.sv
      - verilog/axi_reg_slave.sv
      - verilog/pwl_dma_receiver.sv
      - verilog/batch_buffer.sv
      - verilog/dac_batch_streamer.sv
      - verilog/top_level.sv
  - target: simulation
    files:
      - sim/top_level_properties.sv
      - sim/top_level_tb.sv

// File: sim/top_level_tb.sv
`default_nettype none

module top_level_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dac_sys_pkg::*;

    localparam int BUF_DEPTH      = 16;
    // Rough length of the whole test
    localparam int TEST_LENGTH_NS = 10_000;
    // Watchdog allows four times that
    localparam int WATCHDOG_NS    = 4 * TEST_LENGTH_NS;

    // Byte addresses of the register map
    localparam logic [31:0] ADDR_CTRL   = 32'h0000_0000;
    localparam logic [31:0] ADDR_LOADED = 32'h0000_0004;
    localparam logic [31:0] ADDR_PLAYED = 32'h0000_0008;
    localparam logic [31:0] ADDR_BAD    = 32'h0000_0040;
    localparam logic [1:0]  OKAY        = 2'b00;
    localparam logic [1:0]  SLVERR      = 2'b10;

    logic                   clk;
    logic                   rst_n;
    logic                   dac0_rdy;
    logic [BATCH_WIDTH-1:0] dac_batch;
    logic                   valid_dac_batch;
    logic                   pl_rstn;
    logic [31:0]            raddr_packet;
    logic                   raddr_valid_packet;
    logic [31:0]            waddr_packet;
    logic                   waddr_valid_packet;
    logic [31:0]            wdata_packet;
    logic                   wdata_valid_packet;
    logic                   ps_wresp_rdy;
    logic                   ps_read_rdy;
    logic [1:0]             wresp_out;
    logic [1:0]             rresp_out;
    logic                   wresp_valid_out;
    logic                   rresp_valid_out;
    logic [31:0]            rdata_packet;
    logic                   rdata_valid_out;
    logic [31:0]            pwl_tdata;
    logic                   pwl_tlast;
    logic                   pwl_tvalid;
    logic                   pwl_tready;

    // Reference model holds batches in buffer order
    logic [BATCH_WIDTH-1:0] exp_q[$];
    int                     loaded_batches = 0;
    int                     played = 0;
    int                     errors = 0;

    top_level #(.BUF_DEPTH(BUF_DEPTH)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [BATCH_WIDTH-1:0] got,
                               input logic [BATCH_WIDTH-1:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Address and data pulses in random order and a delayed ready
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int order;
        order = $urandom % 3;
        @(negedge clk);
        waddr_packet       = addr;
        wdata_packet       = data;
        waddr_valid_packet = (order != 2);
        wdata_valid_packet = (order != 1);
        if (order != 0) begin
            // Second half one cycle later
            @(negedge clk);
            waddr_valid_packet = !waddr_valid_packet;
            wdata_valid_packet = !wdata_valid_packet;
        end
        @(negedge clk);
        waddr_valid_packet = 1'b0;
        wdata_valid_packet = 1'b0;
        while (!wresp_valid_out) begin
            @(negedge clk);
        end
        repeat ($urandom % 4) @(negedge clk);
        check_value("wresp_out", wresp_out, exp_resp);
        ps_wresp_rdy = 1'b1;
        @(negedge clk);
        ps_wresp_rdy = 1'b0;
        check_value("wresp_valid_out", wresp_valid_out, 1'b0);
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        @(negedge clk);
        raddr_packet       = addr;
        raddr_valid_packet = 1'b1;
        @(negedge clk);
        raddr_valid_packet = 1'b0;
        while (!(rresp_valid_out && rdata_valid_out)) begin
            @(negedge clk);
        end
        repeat ($urandom % 4) @(negedge clk);
        check_value("rdata_packet", rdata_packet, exp_data);
        check_value("rresp_out", rresp_out, exp_resp);
        ps_read_rdy = 1'b1;
        @(negedge clk);
        ps_read_rdy = 1'b0;
        check_value("rresp_valid_out", rresp_valid_out, 1'b0);
        check_value("rdata_valid_out", rdata_valid_out, 1'b0);
    endtask

    // One DMA frame of random beats with model batches built alongside
    task automatic send_frame(input int n_beats);
        logic [BATCH_WIDTH-1:0] batch;
        logic [31:0]            beat;
        int                     idx;
        batch = '0;
        idx   = 0;
        for (int i = 0; i < n_beats; i++) begin
            beat = $urandom;
            // Earlier beat in the lower bits
            batch[idx*DMA_DATA_WIDTH +: DMA_DATA_WIDTH] = beat;
            idx++;
            if (idx == BEATS_PER_BATCH || i == n_beats - 1) begin
                // Short batch keeps zeros on top
                exp_q.push_back(batch);
                loaded_batches++;
                batch = '0;
                idx   = 0;
            end
            @(negedge clk);
            pwl_tdata  = beat;
            pwl_tvalid = 1'b1;
            pwl_tlast  = (i == n_beats - 1);
            while (!pwl_tready) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        pwl_tvalid = 1'b0;
        pwl_tlast  = 1'b0;
    endtask

    // DAC sink with random ready that checks each taken batch
    task automatic play_batches(input int n_batches);
        int taken;
        taken = 0;
        while (taken < n_batches) begin
            @(negedge clk);
            dac0_rdy = ($urandom % 3) != 0;
            if (valid_dac_batch && dac0_rdy) begin
                check_value("dac_batch", dac_batch, exp_q[played % exp_q.size()]);
                taken++;
                played++;
            end
        end
        @(negedge clk);
        dac0_rdy = 1'b0;
    endtask

    initial begin
        int max_beats;
        void'($urandom(66));
        rst_n              = 1'b0;
        dac0_rdy           = 1'b0;
        raddr_packet       = '0;
        raddr_valid_packet = 1'b0;
        waddr_packet       = '0;
        waddr_valid_packet = 1'b0;
        wdata_packet       = '0;
        wdata_valid_packet = 1'b0;
        ps_wresp_rdy       = 1'b0;
        ps_read_rdy        = 1'b0;
        pwl_tdata          = '0;
        pwl_tlast          = 1'b0;
        pwl_tvalid         = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Idle outputs after reset
        check_value("valid_dac_batch", valid_dac_batch, 1'b0);
        check_value("wresp_valid_out", wresp_valid_out, 1'b0);
        check_value("rresp_valid_out", rresp_valid_out, 1'b0);
        check_value("rdata_valid_out", rdata_valid_out, 1'b0);
        check_value("pl_rstn", pl_rstn, 1'b1);
        check_value("pwl_tready", pwl_tready, 1'b1);
        read_reg(ADDR_LOADED, 32'd0, OKAY);
        read_reg(ADDR_PLAYED, 32'd0, OKAY);

        // Control write and read back
        write_reg(ADDR_CTRL, 32'h1, OKAY);
        read_reg(ADDR_CTRL, 32'h1, OKAY);
        // Read-only and unmapped accesses leave ctrl alone
        write_reg(ADDR_LOADED, 32'h3, SLVERR);
        write_reg(ADDR_BAD, 32'h3, SLVERR);
        read_reg(ADDR_BAD, 32'd0, SLVERR);
        read_reg(ADDR_CTRL, 32'h1, OKAY);
        write_reg(ADDR_CTRL, 32'h0, OKAY);

        // Frames until the buffer is full with the first ending mid-batch
        send_frame(5);
        read_reg(ADDR_LOADED, loaded_batches, OKAY);
        while (loaded_batches < BUF_DEPTH) begin
            max_beats = (BUF_DEPTH - loaded_batches) * BEATS_PER_BATCH;
            if (max_beats > 12) begin
                max_beats = 12;
            end
            send_frame(1 + $urandom % max_beats);
            read_reg(ADDR_LOADED, loaded_batches, OKAY);
        end

        // Full buffer stalls a further beat
        @(negedge clk);
        pwl_tdata  = $urandom;
        pwl_tvalid = 1'b1;
        repeat (8) begin
            check_value("pwl_tready", pwl_tready, 1'b0);
            @(negedge clk);
        end
        pwl_tvalid = 1'b0;
        read_reg(ADDR_LOADED, BUF_DEPTH, OKAY);

        // Play through the buffer and wrap
        write_reg(ADDR_CTRL, 32'h1, OKAY);
        play_batches(BUF_DEPTH + 5);
        read_reg(ADDR_PLAYED, played, OKAY);

        // PL reset clears counts and the batch in flight
        write_reg(ADDR_CTRL, 32'h2, OKAY);
        @(negedge clk);
        check_value("pl_rstn", pl_rstn, 1'b0);
        check_value("valid_dac_batch", valid_dac_batch, 1'b0);
        check_value("pwl_tready", pwl_tready, 1'b0);
        read_reg(ADDR_LOADED, 32'd0, OKAY);
        read_reg(ADDR_PLAYED, 32'd0, OKAY);
        write_reg(ADDR_CTRL, 32'h0, OKAY);
        check_value("pl_rstn", pl_rstn, 1'b1);
        exp_q.delete();
        played         = 0;
        loaded_batches = 0;

        // Fresh frame plays from batch 0
        send_frame(8);
        write_reg(ADDR_CTRL, 32'h1, OKAY);
        play_batches(3);
        read_reg(ADDR_PLAYED, 32'd3, OKAY);

        $display("Errors: %0d check, %0d assertion", errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/top_level_properties.sv
`default_nettype none

module top_level_properties #(
    parameter int BUF_DEPTH = 16
) (
    input wire                                  clk,
    input wire                                  rst_n,
    // DAC side
    input wire                                  dac0_rdy,
    input wire [dac_sys_pkg::BATCH_WIDTH-1:0]   dac_batch,
    input wire                                  valid_dac_batch,
    input wire                                  pl_rstn,
    // Processor responses
    input wire [1:0]                            wresp_out,
    input wire                                  wresp_valid_out,
    input wire                                  ps_wresp_rdy,
    input wire [1:0]                            rresp_out,
    input wire                                  rresp_valid_out,
    input wire [dac_sys_pkg::WD_BUS_WIDTH-1:0]  rdata_packet,
    input wire                                  rdata_valid_out,
    input wire                                  ps_read_rdy,
    // Stream and internal state
    input wire                                  pwl_tready,
    input wire dac_sys_pkg::ctrl_reg_t          ctrl,
    input wire dac_sys_pkg::batch_cnt_t         loaded_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import dac_sys_pkg::*;

    int fail_count = 0;

    // Batch held until the DAC takes it, pl_reset may drop it
    dac_hold: assert property (@(posedge clk) disable iff (!rst_n || ctrl.pl_reset)
        valid_dac_batch && !dac0_rdy |=> valid_dac_batch && $stable(dac_batch))
    else begin
        fail_count++;
        $error("DAC batch changed while dac0_rdy was low");
    end

    wresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wresp_valid_out && !ps_wresp_rdy |=> wresp_valid_out && $stable(wresp_out))
    else begin
        fail_count++;
        $error("Write response dropped or changed before ps_wresp_rdy");
    end

    // Data and response valids travel together
    rresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rresp_valid_out && !ps_read_rdy |=> rresp_valid_out && rdata_valid_out &&
        $stable(rdata_packet) && $stable(rresp_out))
    else begin
        fail_count++;
        $error("Read response dropped or changed before ps_read_rdy");
    end

    no_dac_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !pl_rstn |-> !valid_dac_batch)
    else begin
        fail_count++;
        $error("valid_dac_batch high while pl_rstn low");
    end

    // Full buffer blocks the stream
    full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        loaded_count == batch_cnt_t'(BUF_DEPTH) |-> !pwl_tready)
    else begin
        fail_count++;
        $error("pwl_tready high with a full buffer");
    end

endmodule

bind top_level top_level_properties #(.BUF_DEPTH(BUF_DEPTH)) u_props (
    .clk(clk),
    .rst_n(rst_n),
    .dac0_rdy(dac0_rdy),
    .dac_batch(dac_batch),
    .valid_dac_batch(valid_dac_batch),
    .pl_rstn(pl_rstn),
    .wresp_out(wresp_out),
    .wresp_valid_out(wresp_valid_out),
    .ps_wresp_rdy(ps_wresp_rdy),
    .rresp_out(rresp_out),
    .rresp_valid_out(rresp_valid_out),
    .rdata_packet(rdata_packet),
    .rdata_valid_out(rdata_valid_out),
    .ps_read_rdy(ps_read_rdy),
    .pwl_tready(pwl_tready),
    .ctrl(ctrl),
    .loaded_count(loaded_count)
);

`default_nettype wire

// File: verilog/top_level.sv
`default_nettype none

module top_level #(
    parameter int BUF_DEPTH = 16
) (
    input  wire                                    clk,
    input  wire                                    rst_n,
    // DAC
    input  wire                                    dac0_rdy,
    output logic [dac_sys_pkg::BATCH_WIDTH-1:0]    dac_batch,
    output logic                                   valid_dac_batch,
    output logic                                   pl_rstn,
    // Processor requests
    input  wire  [dac_sys_pkg::A_BUS_WIDTH-1:0]    raddr_packet,
    input  wire                                    raddr_valid_packet,
    input  wire  [dac_sys_pkg::A_BUS_WIDTH-1:0]    waddr_packet,
    input  wire                                    waddr_valid_packet,
    input  wire  [dac_sys_pkg::WD_BUS_WIDTH-1:0]   wdata_packet,
    input  wire                                    wdata_valid_packet,
    input  wire                                    ps_wresp_rdy,
    input  wire                                    ps_read_rdy,
    // Processor responses
    output logic [1:0]                             wresp_out,
    output logic [1:0]                             rresp_out,
    output logic                                   wresp_valid_out,
    output logic                                   rresp_valid_out,
    output logic [dac_sys_pkg::WD_BUS_WIDTH-1:0]   rdata_packet,
    output logic                                   rdata_valid_out,
    // DMA stream
    input  wire  [dac_sys_pkg::DMA_DATA_WIDTH-1:0] pwl_tdata,
    input  wire                                    pwl_tlast,
    input  wire                                    pwl_tvalid,
    output logic                                   pwl_tready
);
    import dac_sys_pkg::*;

    ctrl_reg_t              ctrl;
    batch_cnt_t             loaded_count;
    batch_cnt_t             played_count;
    buf_wr_t                buf_wr;
    buf_addr_t              rd_addr;
    logic [BATCH_WIDTH-1:0] rd_batch;

    // Register slave
    axi_reg_slave u_regs (
        .clk(clk), .rst_n(rst_n),
        .waddr_packet(waddr_packet), .waddr_valid_packet(waddr_valid_packet),
        .wdata_packet(wdata_packet), .wdata_valid_packet(wdata_valid_packet),
        .ps_wresp_rdy(ps_wresp_rdy),
        .raddr_packet(raddr_packet), .raddr_valid_packet(raddr_valid_packet),
        .ps_read_rdy(ps_read_rdy),
        .loaded_count(loaded_count), .played_count(played_count),
        .wresp_out(wresp_out), .wresp_valid_out(wresp_valid_out),
        .rdata_packet(rdata_packet), .rdata_valid_out(rdata_valid_out),
        .rresp_out(rresp_out), .rresp_valid_out(rresp_valid_out),
        .ctrl(ctrl), .pl_rstn(pl_rstn)
    );

    // Stream to buffer
    pwl_dma_receiver #(.BUF_DEPTH(BUF_DEPTH)) u_rx (
        .clk(clk), .rst_n(rst_n),
        .pwl_tdata(pwl_tdata), .pwl_tvalid(pwl_tvalid), .pwl_tlast(pwl_tlast),
        .ctrl(ctrl), .pwl_tready(pwl_tready),
        .buf_wr(buf_wr), .loaded_count(loaded_count)
    );

    batch_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
        .clk(clk), .buf_wr(buf_wr), .rd_addr(rd_addr), .rd_batch(rd_batch)
    );

    // Buffer to DAC
    dac_batch_streamer #(.BUF_DEPTH(BUF_DEPTH)) u_stream (
        .clk(clk), .rst_n(rst_n),
        .ctrl(ctrl), .loaded_count(loaded_count),
        .rd_batch(rd_batch), .rd_addr(rd_addr),
        .dac0_rdy(dac0_rdy), .dac_batch(dac_batch),
        .valid_dac_batch(valid_dac_batch), .played_count(played_count)
    );

endmodule

`default_nettype wire

// File: verilog/dac_batch_streamer.sv
`default_nettype none

module dac_batch_streamer #(
    parameter int BUF_DEPTH = 16
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  dac_sys_pkg::ctrl_reg_t        ctrl,
    input  wire  dac_sys_pkg::batch_cnt_t       loaded_count,
    // Buffer read port
    input  wire  [dac_sys_pkg::BATCH_WIDTH-1:0] rd_batch,
    output dac_sys_pkg::buf_addr_t              rd_addr,
    // DAC side
    input  wire                                 dac0_rdy,
    output logic [dac_sys_pkg::BATCH_WIDTH-1:0] dac_batch,
    output logic                                valid_dac_batch,
    // Accepted batches, wraps
    output dac_sys_pkg::batch_cnt_t             played_count
);
    import dac_sys_pkg::*;

    dac_state_e state;
    buf_addr_t  play_idx;
    batch_cnt_t next_cnt;
    logic       wrap;
    logic       accept;

    // DAC takes the batch this cycle
    assign accept   = (state == DAC_PRESENT) && valid_dac_batch && dac0_rdy;

    // Next index, back to zero past the last stored batch
    assign next_cnt = batch_cnt_t'(play_idx) + 1'b1;
    assign wrap     = (next_cnt >= loaded_count) ||
                      (next_cnt >= batch_cnt_t'(BUF_DEPTH));

    // Read address is frozen while presenting, so the read data holds
    assign dac_batch = rd_batch;

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.pl_reset) begin
            state           <= DAC_IDLE;
            valid_dac_batch <= 1'b0;
            play_idx        <= '0;
            rd_addr         <= '0;
            played_count    <= '0;
        end else begin
            case (state)
                DAC_IDLE: begin
                    // Wait for run and something to play
                    if (ctrl.run && loaded_count != '0) begin
                        state <= DAC_FETCH;
                    end
                end
                DAC_FETCH: begin
                    // Issue the address
                    rd_addr <= play_idx;
                    state   <= DAC_PRESENT;
                end
                DAC_PRESENT: begin
                    if (!valid_dac_batch) begin
                        // Memory read has landed
                        valid_dac_batch <= 1'b1;
                    end else if (accept) begin
                        valid_dac_batch <= 1'b0;
                        played_count    <= played_count + 1'b1;
                        play_idx        <= wrap ? '0 : next_cnt[BUF_ADDR_WIDTH-1:0];
                        // Cleared run stops here
                        state           <= ctrl.run ? DAC_FETCH : DAC_IDLE;
                    end
                end
                default: begin
                    state           <= DAC_IDLE;
                    valid_dac_batch <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/batch_buffer.sv
`default_nettype none

module batch_buffer #(
    parameter int BUF_DEPTH = 16
) (
    input  wire                                 clk,
    // Write port from the DMA receiver
    input  wire  dac_sys_pkg::buf_wr_t          buf_wr,
    // Read port toward the streamer
    input  wire  dac_sys_pkg::buf_addr_t        rd_addr,
    output logic [dac_sys_pkg::BATCH_WIDTH-1:0] rd_batch
);
    import dac_sys_pkg::*;

    // Index bits actually needed for this depth
    localparam int IDX_WIDTH = $clog2(BUF_DEPTH);

    logic [BATCH_WIDTH-1:0] mem [BUF_DEPTH];
    logic [IDX_WIDTH-1:0]   wr_idx;
    logic [IDX_WIDTH-1:0]   rd_idx;

    assign wr_idx = buf_wr.addr[IDX_WIDTH-1:0];
    assign rd_idx = rd_addr[IDX_WIDTH-1:0];

    // Write port
    always_ff @(posedge clk) begin
        if (buf_wr.en) begin
            mem[wr_idx] <= buf_wr.data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_batch <= mem[rd_idx];
    end

endmodule

`default_nettype wire

// File: verilog/pwl_dma_receiver.sv
`default_nettype none

module pwl_dma_receiver #(
    parameter int BUF_DEPTH = 16
) (
    input  wire                                    clk,
    input  wire                                    rst_n,
    // DMA stream in
    input  wire  [dac_sys_pkg::DMA_DATA_WIDTH-1:0] pwl_tdata,
    input  wire                                    pwl_tvalid,
    input  wire                                    pwl_tlast,
    input  wire  dac_sys_pkg::ctrl_reg_t           ctrl,
    output logic                                   pwl_tready,
    // Buffer write port
    output dac_sys_pkg::buf_wr_t                   buf_wr,
    // Batches stored since last pl_reset
    output dac_sys_pkg::batch_cnt_t                loaded_count
);
    import dac_sys_pkg::*;

    localparam int BEAT_IDX_WIDTH = $clog2(BEATS_PER_BATCH);

    logic [BEAT_IDX_WIDTH-1:0] beat_idx;
    logic [BEAT_IDX_WIDTH-1:0] pad_words;
    logic [BATCH_WIDTH-1:0]    shift_q;
    logic [BATCH_WIDTH-1:0]    shift_next;
    logic                      buf_full;
    logic                      beat_fire;
    logic                      batch_done;

    // Count doubles as the full detector
    assign buf_full   = (loaded_count == batch_cnt_t'(BUF_DEPTH));
    assign pwl_tready = !ctrl.pl_reset && !buf_full;
    assign beat_fire  = pwl_tvalid && pwl_tready;

    // Last beat of a batch, either the fourth or a tlast
    assign batch_done = beat_fire &&
                        (pwl_tlast || beat_idx == BEAT_IDX_WIDTH'(BEATS_PER_BATCH - 1));

    // New beat enters at the top and older beats move down
    assign shift_next = {pwl_tdata, shift_q[BATCH_WIDTH-1:DMA_DATA_WIDTH]};

    // Words still missing from a short batch
    assign pad_words  = BEAT_IDX_WIDTH'(BEATS_PER_BATCH - 1) - beat_idx;

    // Write goes out in the same edge as the closing beat
    always_comb begin
        buf_wr.en   = batch_done;
        // Next free slot is the current count
        buf_wr.addr = loaded_count[BUF_ADDR_WIDTH-1:0];
        // Align a partial batch to the bottom, zeros fill the top
        buf_wr.data = shift_next >> (pad_words * DMA_DATA_WIDTH);
    end

    // Beat index and stored batch count
    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.pl_reset) begin
            beat_idx     <= '0;
            loaded_count <= '0;
        end else if (beat_fire) begin
            if (batch_done) begin
                beat_idx     <= '0;
                loaded_count <= loaded_count + 1'b1;
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    // Partial batch shift register
    always_ff @(posedge clk) begin
        if (beat_fire) begin
            shift_q <= shift_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/axi_reg_slave.sv
`default_nettype none

module axi_reg_slave (
    input  wire                                   clk,
    input  wire                                   rst_n,
    // Write address and data channels, one-cycle valid pulses
    input  wire  [dac_sys_pkg::A_BUS_WIDTH-1:0]   waddr_packet,
    input  wire                                   waddr_valid_packet,
    input  wire  [dac_sys_pkg::WD_BUS_WIDTH-1:0]  wdata_packet,
    input  wire                                   wdata_valid_packet,
    input  wire                                   ps_wresp_rdy,
    // Read address channel
    input  wire  [dac_sys_pkg::A_BUS_WIDTH-1:0]   raddr_packet,
    input  wire                                   raddr_valid_packet,
    input  wire                                   ps_read_rdy,
    // Status from the datapath
    input  wire  dac_sys_pkg::batch_cnt_t         loaded_count,
    input  wire  dac_sys_pkg::batch_cnt_t         played_count,
    // Responses, held until the matching ready
    output dac_sys_pkg::axi_resp_e                wresp_out,
    output logic                                  wresp_valid_out,
    output logic [dac_sys_pkg::WD_BUS_WIDTH-1:0]  rdata_packet,
    output logic                                  rdata_valid_out,
    output dac_sys_pkg::axi_resp_e                rresp_out,
    output logic                                  rresp_valid_out,
    // Control outputs
    output dac_sys_pkg::ctrl_reg_t                ctrl,
    output logic                                  pl_rstn
);
    import dac_sys_pkg::*;

    localparam int WORD_WIDTH = A_BUS_WIDTH - 2;

    logic [A_BUS_WIDTH-1:0]  waddr_q;
    logic [WD_BUS_WIDTH-1:0] wdata_q;
    logic                    waddr_held;
    logic                    wdata_held;
    logic                    do_write;
    logic                    wr_hit;
    logic [WORD_WIDTH-1:0]   wr_word;
    logic [WORD_WIDTH-1:0]   rd_word;
    logic [WD_BUS_WIDTH-1:0] rd_value;
    axi_resp_e               rd_code;

    // Byte addresses to word addresses
    assign wr_word = waddr_q[A_BUS_WIDTH-1:2];
    assign rd_word = raddr_packet[A_BUS_WIDTH-1:2];

    // Write fires once both halves are held and no response is pending
    assign do_write = waddr_held && wdata_held && !wresp_valid_out;
    // Only the control register is writable
    assign wr_hit   = (wr_word == REG_CTRL);

    // Read decode
    always_comb begin
        rd_value = '0;
        rd_code  = RESP_OKAY;
        case (rd_word)
            REG_CTRL:   rd_value[$bits(ctrl_reg_t)-1:0]  = ctrl;
            REG_LOADED: rd_value[$bits(batch_cnt_t)-1:0] = loaded_count;
            REG_PLAYED: rd_value[$bits(batch_cnt_t)-1:0] = played_count;
            default:    rd_code = RESP_SLVERR;
        endcase
    end

    // Pending flags for address and data, arriving in either order
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            waddr_held <= 1'b0;
            wdata_held <= 1'b0;
        end else begin
            if (waddr_valid_packet) begin
                waddr_held <= 1'b1;
            end else if (do_write) begin
                waddr_held <= 1'b0;
            end
            if (wdata_valid_packet) begin
                wdata_held <= 1'b1;
            end else if (do_write) begin
                wdata_held <= 1'b0;
            end
        end
    end

    // Captured address and data words
    always_ff @(posedge clk) begin
        if (waddr_valid_packet) begin
            waddr_q <= waddr_packet;
        end
        if (wdata_valid_packet) begin
            wdata_q <= wdata_packet;
        end
    end

    // Control register, PL reset output and write response valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl            <= '0;
            pl_rstn         <= 1'b1;
            wresp_valid_out <= 1'b0;
        end else begin
            // Active-low copy of pl_reset, one cycle behind
            pl_rstn <= ~ctrl.pl_reset;
            if (do_write) begin
                wresp_valid_out <= 1'b1;
                if (wr_hit) begin
                    ctrl <= ctrl_reg_t'(wdata_q[$bits(ctrl_reg_t)-1:0]);
                end
            end else if (wresp_valid_out && ps_wresp_rdy) begin
                wresp_valid_out <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            wresp_out <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Read response valids, both set together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_valid_out <= 1'b0;
            rresp_valid_out <= 1'b0;
        end else if (raddr_valid_packet) begin
            rdata_valid_out <= 1'b1;
            rresp_valid_out <= 1'b1;
        end else if (rresp_valid_out && ps_read_rdy) begin
            rdata_valid_out <= 1'b0;
            rresp_valid_out <= 1'b0;
        end
    end

    // Read payload captured with the address pulse
    always_ff @(posedge clk) begin
        if (raddr_valid_packet) begin
            rdata_packet <= rd_value;
            rresp_out    <= rd_code;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dac_sys_pkg.sv
`default_nettype none

package dac_sys_pkg;

    // Sample and stream geometry
    localparam int SAMPLE_WIDTH    = 16;
    localparam int DMA_DATA_WIDTH  = 32;
    localparam int BATCH_SAMPLES   = 8;
    localparam int BATCH_WIDTH     = BATCH_SAMPLES * SAMPLE_WIDTH;
    // Two samples per beat, so four beats fill a batch
    localparam int BEATS_PER_BATCH = BATCH_WIDTH / DMA_DATA_WIDTH;

    // Processor bus widths
    localparam int A_BUS_WIDTH     = 32;
    localparam int WD_BUS_WIDTH    = 32;

    // Buffer index covers up to 256 batches
    localparam int BUF_ADDR_WIDTH  = 8;

    typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;
    // One extra bit so a full 256-entry buffer can be counted
    typedef logic [BUF_ADDR_WIDTH:0]   batch_cnt_t;

    // Register map, word addresses (byte address >> 2)
    typedef enum logic [A_BUS_WIDTH-3:0] {
        REG_CTRL   = 0,
        REG_LOADED = 1,
        REG_PLAYED = 2
    } reg_addr_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_FETCH,
        DAC_PRESENT
    } dac_state_e;

    // Control register, bit 1 pl_reset and bit 0 run
    typedef struct packed {
        logic pl_reset;
        logic run;
    } ctrl_reg_t;

    // Buffer write port bundle
    typedef struct packed {
        logic                   en;
        buf_addr_t              addr;
        logic [BATCH_WIDTH-1:0] data;
    } buf_wr_t;

endpackage

`default_nettype wire
